// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= alu_core_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_TEXT  ?= all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
rtl/alu_pkg.sv
rtl/alu_ifs.sv
rtl/alu_regfile.sv
rtl/alu_decode.sv
rtl/alu_execute.sv
rtl/alu_result.sv
rtl/alu_core_top.sv
tests/alu_core_asserts.sv
tests/alu_core_checker.sv
tests/alu_core_tb.sv

// ==== rtl/alu_core_top.sv ====
// alu core top level, credit-controlled instruction input and result output
`timescale 1ns/10ps

module alu_core_top #(
   parameter int in_depth    = 4,   // input queue slots
   parameter int out_credits = 2    // result slots at the consumer
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          in_valid,
   input  logic [alu_pkg::data_w-1:0]    in_instr,
   output logic                          in_credit,
   output logic                          out_valid,
   output logic [alu_pkg::reg_idx_w-1:0] out_rd,
   output logic [alu_pkg::data_w-1:0]    out_data,
   output logic [alu_pkg::flags_w-1:0]   out_flags,
   input  logic                          out_credit
);
   import alu_pkg::*;

   logic [reg_idx_w-1:0] ra1;        // decode read indices
   logic [reg_idx_w-1:0] ra2;
   logic [data_w-1:0]    rd1;
   logic [data_w-1:0]    rd2;
   logic                 we;         // writeback from result stage
   logic [reg_idx_w-1:0] waddr;
   logic [data_w-1:0]    wdata;
   logic                 wb_valid;   // scoreboard clear
   logic [reg_idx_w-1:0] wb_rd;

   issue_if  iss_bus ();
   retire_if ret_bus ();

   alu_regfile u_regfile (
      .clk   (clk),
      .arst_n(arst_n),
      .ra1   (ra1),
      .ra2   (ra2),
      .rd1   (rd1),
      .rd2   (rd2),
      .we    (we),
      .waddr (waddr),
      .wdata (wdata)
   );

   alu_decode #(
      .in_depth(in_depth)
   ) u_decode (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_valid (in_valid),
      .in_instr (in_instr),
      .in_credit(in_credit),
      .ra1      (ra1),
      .ra2      (ra2),
      .rd1      (rd1),
      .rd2      (rd2),
      .wb_valid (wb_valid),
      .wb_rd    (wb_rd),
      .iss      (iss_bus.source)
   );

   alu_execute u_execute (
      .clk   (clk),
      .arst_n(arst_n),
      .iss   (iss_bus.sink),
      .ret   (ret_bus.source)
   );

   alu_result #(
      .out_credits(out_credits)
   ) u_result (
      .clk       (clk),
      .arst_n    (arst_n),
      .ret       (ret_bus.sink),
      .out_credit(out_credit),
      .out_valid (out_valid),
      .out_rd    (out_rd),
      .out_data  (out_data),
      .out_flags (out_flags),
      .we        (we),
      .waddr     (waddr),
      .wdata     (wdata),
      .wb_valid  (wb_valid),
      .wb_rd     (wb_rd)
   );

endmodule

// ==== rtl/alu_decode.sv ====
// credit-fed instruction queue, field decode, operand read and busy-register scoreboard
`timescale 1ns/10ps

module alu_decode #(
   parameter int in_depth = 4                            // queue slots, also sender credits
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          in_valid,       // one word per spent credit
   input  logic [alu_pkg::data_w-1:0]    in_instr,
   output logic                          in_credit,      // pulse per word leaving the queue
   output logic [alu_pkg::reg_idx_w-1:0] ra1,
   output logic [alu_pkg::reg_idx_w-1:0] ra2,
   input  logic [alu_pkg::data_w-1:0]    rd1,
   input  logic [alu_pkg::data_w-1:0]    rd2,
   input  logic                          wb_valid,       // register written this cycle
   input  logic [alu_pkg::reg_idx_w-1:0] wb_rd,
   issue_if.source                       iss
);
   import alu_pkg::*;

   localparam int ptr_w = (in_depth > 1) ? $clog2(in_depth) : 1;
   localparam int cnt_w = $clog2(in_depth + 1);

   logic [data_w-1:0]    queue [in_depth];   // instruction words
   logic [ptr_w-1:0]     wr_ptr;
   logic [ptr_w-1:0]     rd_ptr;
   logic [cnt_w-1:0]     count;              // occupied slots
   logic [reg_count-1:0] busy;               // write pending per register
   instr_u               head;               // oldest word, both views
   logic                 use_rs2;
   logic                 hazard;
   logic                 pop;
   logic [data_w-1:0]    op_b;

   // wraps for depths that are not a power of two
   function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
      ptr_next = (p == ptr_w'(in_depth - 1)) ? '0 : p + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (in_valid) begin
         queue[wr_ptr] <= in_instr;   // sender credits keep this from overrunning
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         in_credit <= 1'b0;
      end else begin
         if (in_valid) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         count     <= count + cnt_w'(in_valid) - cnt_w'(pop);
         in_credit <= pop;            // slot freed, hand credit back
      end
   end

   assign head = queue[rd_ptr];

   // rs1 and rs2 sit at the same bits in both layouts
   assign ra1     = head.rr.rs1;
   assign ra2     = head.rr.rs2;
   assign use_rs2 = !head.rr.fmt && (head.rr.op != op_inc);   // inc and ri skip rs2

   // raw on sources, waw on rd
   assign hazard = busy[head.rr.rs1]
                 | (use_rs2 & busy[head.rr.rs2])
                 | busy[head.rr.rd];

   always_comb begin
      if (head.rr.op == op_inc) begin
         op_b = data_w'(1);
      end else if (head.ri.fmt) begin
         op_b = {{(data_w - imm_w){head.ri.imm[imm_w-1]}}, head.ri.imm};   // sign extend
      end else begin
         op_b = rd2;
      end
   end

   // busy bits only clear while the head waits, so valid holds once raised
   assign iss.valid = (count != '0) && !hazard;
   assign iss.op    = head.rr.op;
   assign iss.rd    = head.rr.rd;
   assign iss.a     = rd1;
   assign iss.b     = op_b;
   assign iss.shamt = op_b[shamt_w-1:0];
   assign pop       = iss.valid && iss.ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy <= '0;
      end else begin
         if (wb_valid) begin
            busy[wb_rd] <= 1'b0;          // value now in the register file
         end
         if (pop) begin
            busy[head.rr.rd] <= 1'b1;     // never the same reg as wb_rd, rd was free
         end
      end
   end

endmodule

// ==== rtl/alu_execute.sv ====
// registered alu stage, computes the result and the flags each operation would set
`timescale 1ns/10ps

module alu_execute (
   input  logic     clk,
   input  logic     arst_n,
   issue_if.sink    iss,
   retire_if.source ret
);
   import alu_pkg::*;

   logic [data_w-1:0]  result;
   logic [flags_w-1:0] flags;
   logic               carry;      // add carry or sub borrow, bit 16
   logic               arith;      // add, sub, inc
   logic               shift_op;   // flags left alone
   logic               take;

   always_comb begin
      carry  = 1'b0;
      arith  = 1'b0;
      result = '0;
      case (iss.op)
         op_add, op_inc: begin
            {carry, result} = {1'b0, iss.a} + {1'b0, iss.b};   // inc arrives with b = 1
            arith           = 1'b1;
         end
         op_sub: begin
            {carry, result} = {1'b0, iss.a} - {1'b0, iss.b};   // wraps to 1 on borrow
            arith           = 1'b1;
         end
         op_andn: result = iss.a & ~iss.b;
         op_xor:  result = iss.a ^ iss.b;
         op_sra:  result = $signed(iss.a) >>> iss.shamt;       // sign fills
         op_srl:  result = iss.a >> iss.shamt;
         op_sll:  result = iss.a << iss.shamt;
      endcase
   end

   assign shift_op = (iss.op == op_sra) || (iss.op == op_srl) || (iss.op == op_sll);

   // logic ops keep only z
   always_comb begin
      flags         = '0;
      flags[flag_z] = (result == '0);
      flags[flag_v] = arith & carry;
      flags[flag_n] = arith & result[data_w-1];
   end

   assign iss.ready = !ret.valid || ret.ready;   // empty or draining
   assign take      = iss.valid && iss.ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ret.valid <= 1'b0;
      end else if (iss.ready) begin
         ret.valid <= iss.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         ret.rd         <= iss.rd;
         ret.value      <= result;
         ret.cand_flags <= flags;
         ret.flags_we   <= !shift_op;
      end
   end

endmodule

// ==== rtl/alu_ifs.sv ====
// internal handshake bundles of the alu core, decode to execute and execute to result
`timescale 1ns/10ps

interface issue_if;
   import alu_pkg::*;

   logic                 valid;   // held with stable fields until taken
   logic                 ready;
   logic [op_w-1:0]      op;
   logic [data_w-1:0]    a;       // rs1 value
   logic [data_w-1:0]    b;       // rs2, immediate or one
   logic [shamt_w-1:0]   shamt;   // low bits of b
   logic [reg_idx_w-1:0] rd;

   modport source (output valid, op, a, b, shamt, rd, input ready);
   modport sink   (input valid, op, a, b, shamt, rd, output ready);

endinterface

interface retire_if;
   import alu_pkg::*;

   logic                 valid;
   logic                 ready;        // tied to output credit availability
   logic [reg_idx_w-1:0] rd;
   logic [data_w-1:0]    value;
   logic [flags_w-1:0]   cand_flags;   // flags this op would set
   logic                 flags_we;     // low for shifts

   modport source (output valid, rd, value, cand_flags, flags_we, input ready);
   modport sink   (input valid, rd, value, cand_flags, flags_we, output ready);

endinterface

// ==== rtl/alu_pkg.sv ====
// widths, opcodes, flag bit positions and the instruction word layout shared by the alu core
package alu_pkg;

   localparam int data_w    = 16;     // datapath and instruction word width
   localparam int reg_count = 8;      // architectural registers r0..r7
   localparam int reg_idx_w = 3;      // register index bits
   localparam int op_w      = 3;      // opcode field
   localparam int flags_w   = 3;      // {z, v, n}
   localparam int shamt_w   = 4;      // shift distance 0..15
   localparam int imm_w     = 6;      // signed immediate of the ri form

   localparam logic [op_w-1:0] op_add  = 3'd0;
   localparam logic [op_w-1:0] op_sub  = 3'd1;
   localparam logic [op_w-1:0] op_andn = 3'd2;   // a and not b
   localparam logic [op_w-1:0] op_xor  = 3'd3;
   localparam logic [op_w-1:0] op_inc  = 3'd4;   // a + 1
   localparam logic [op_w-1:0] op_sra  = 3'd5;
   localparam logic [op_w-1:0] op_srl  = 3'd6;
   localparam logic [op_w-1:0] op_sll  = 3'd7;

   localparam int flag_z = 2;   // result is zero
   localparam int flag_v = 1;   // carry out of add, borrow of sub
   localparam int flag_n = 0;   // result msb

   // one 16-bit word, two field layouts selected by fmt
   typedef union packed {
      struct packed {
         logic [op_w-1:0]      op;     // 15:13
         logic                 fmt;    // 12, low here
         logic [reg_idx_w-1:0] rd;
         logic [reg_idx_w-1:0] rs1;
         logic [reg_idx_w-1:0] rs2;
         logic [2:0]           pad;    // unused
      } rr;
      struct packed {
         logic [op_w-1:0]         op;
         logic                    fmt;    // high here
         logic [reg_idx_w-1:0]    rd;
         logic [reg_idx_w-1:0]    rs1;
         logic signed [imm_w-1:0] imm;    // low 4 bits double as shift distance
      } ri;
   } instr_u;

endpackage

// ==== rtl/alu_regfile.sv ====
// eight general registers with two combinational read ports and one clocked write port
`timescale 1ns/10ps

module alu_regfile (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic [alu_pkg::reg_idx_w-1:0] ra1,     // rs1 index from decode
   input  logic [alu_pkg::reg_idx_w-1:0] ra2,     // rs2 index from decode
   output logic [alu_pkg::data_w-1:0]    rd1,
   output logic [alu_pkg::data_w-1:0]    rd2,
   input  logic                          we,      // writeback strobe from result stage
   input  logic [alu_pkg::reg_idx_w-1:0] waddr,
   input  logic [alu_pkg::data_w-1:0]    wdata
);
   import alu_pkg::*;

   logic [data_w-1:0] regs [reg_count];

   // reads see the array directly, no bypass of a same-cycle write
   assign rd1 = regs[ra1];
   assign rd2 = regs[ra2];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;             // all registers start at zero
         end
      end else if (we) begin
         regs[waddr] <= wdata;
      end
   end

endmodule

// ==== rtl/alu_result.sv ====
// writeback, flag register and output credit tracking, one result beat per instruction
`timescale 1ns/10ps

module alu_result #(
   parameter int out_credits = 2                         // consumer slots at reset
) (
   input  logic                          clk,
   input  logic                          arst_n,
   retire_if.sink                        ret,
   input  logic                          out_credit,     // consumer freed a slot
   output logic                          out_valid,
   output logic [alu_pkg::reg_idx_w-1:0] out_rd,
   output logic [alu_pkg::data_w-1:0]    out_data,
   output logic [alu_pkg::flags_w-1:0]   out_flags,      // flag word after this op
   output logic                          we,
   output logic [alu_pkg::reg_idx_w-1:0] waddr,
   output logic [alu_pkg::data_w-1:0]    wdata,
   output logic                          wb_valid,       // scoreboard clear
   output logic [alu_pkg::reg_idx_w-1:0] wb_rd
);
   import alu_pkg::*;

   localparam int cnt_w = $clog2(out_credits + 1);

   logic [cnt_w-1:0]     credit_cnt;   // taken at retire, back on out_credit
   logic [flags_w-1:0]   flags_q;      // z v n
   logic                 valid_q;
   logic [reg_idx_w-1:0] rd_q;
   logic [data_w-1:0]    value_q;
   logic                 fire;

   assign ret.ready = (credit_cnt != '0);   // only accept what the consumer can hold
   assign fire      = ret.valid && ret.ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credit_cnt <= cnt_w'(out_credits);
         valid_q    <= 1'b0;
         flags_q    <= '0;
      end else begin
         credit_cnt <= credit_cnt - cnt_w'(fire) + cnt_w'(out_credit);
         valid_q    <= fire;
         if (fire && ret.flags_we) begin
            flags_q <= ret.cand_flags;   // shifts leave the old word
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         rd_q    <= ret.rd;
         value_q <= ret.value;
      end
   end

   // beat to the consumer
   assign out_valid = valid_q;
   assign out_rd    = rd_q;
   assign out_data  = value_q;
   assign out_flags = flags_q;       // updated on the same edge as the beat

   // register file write lands on the edge that ends the beat
   assign we    = valid_q;
   assign waddr = rd_q;
   assign wdata = value_q;

   // busy bit drops together with the write
   assign wb_valid = valid_q;
   assign wb_rd    = rd_q;

endmodule

// ==== tests/alu_core_asserts.sv ====
// output credit rules of the result stage, bound into alu_result
`timescale 1ns/10ps

module alu_core_asserts #(
   parameter int out_credits = 2
) (
   input logic                                 clk,
   input logic                                 arst_n,
   input logic                                 out_valid,
   input logic                                 out_credit,
   input logic                                 ret_ready,
   input logic [$clog2(out_credits + 1)-1:0]   credit_cnt
);

   int beats_seen;     // beats in earlier cycles
   int credits_back;   // out_credit pulses taken so far
   int model_cnt;      // credits the stage should hold now

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         beats_seen   <= 0;
         credits_back <= 0;
      end else begin
         beats_seen   <= beats_seen + int'(out_valid);
         credits_back <= credits_back + int'(out_credit);
      end
   end

   // a beat spends its credit on the edge that raises it
   assign model_cnt = out_credits + credits_back - beats_seen - int'(out_valid);

   // each beat spent a credit on the cycle before
   beat_had_credit: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid |-> $past(model_cnt) > 0)
      else $error("output beat without a credit");

   credits_bounded: assert property (@(posedge clk) disable iff (!arst_n)
      credit_cnt <= out_credits)
      else $error("credit count above the reset value");

   quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
      else $error("output beat during reset");

   no_ready_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
      model_cnt == 0 |-> !ret_ready)
      else $error("retire ready high with no credits");

endmodule

// ==== tests/alu_core_checker.sv ====
// watches the alu core ports, keeps a register and flag model and compares every result beat
`timescale 1ns/10ps

module alu_core_checker (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          in_valid,
   input  logic [alu_pkg::data_w-1:0]    in_instr,
   input  logic                          out_valid,
   input  logic [alu_pkg::reg_idx_w-1:0] out_rd,
   input  logic [alu_pkg::data_w-1:0]    out_data,
   input  logic [alu_pkg::flags_w-1:0]   out_flags,
   output int                            errors,
   output int                            beats
);
   import alu_pkg::*;

   logic [data_w-1:0]  model_regs [reg_count];
   logic [flags_w-1:0] model_flags;
   instr_u             pending [$];   // accepted words, oldest first

   // expected {flags, value} from the instruction rules
   function automatic logic [flags_w+data_w-1:0] expected_beat(input instr_u w,
         input logic [data_w-1:0] a, input logic [data_w-1:0] r2,
         input logic [flags_w-1:0] prev);
      logic [data_w-1:0]  b;
      logic [data_w-1:0]  y;
      logic [flags_w-1:0] f;
      logic               v;
      logic               arith;
      int unsigned        sum;
      if (w.rr.op == op_inc) b = 16'd1;
      else if (w.ri.fmt) b = 16'($signed(w.ri.imm));   // sign extended immediate
      else b = r2;
      v     = 1'b0;
      arith = (w.rr.op == op_add) || (w.rr.op == op_sub) || (w.rr.op == op_inc);
      sum   = int'(a) + int'(b);
      case (w.rr.op)
         op_add, op_inc: begin
            y = 16'(sum);
            v = sum > 32'h0000_ffff;                 // carry out
         end
         op_sub: begin
            y = a - b;
            v = a < b;                               // borrow
         end
         op_andn: y = a & ~b;
         op_xor:  y = a ^ b;
         op_srl:  y = a >> b[3:0];
         op_sll:  y = a << b[3:0];
         default: begin                              // sra, one bit at a time
            y = a;
            for (int i = 0; i < 15; i++) begin
               if (i < int'(b[3:0])) y = {y[data_w-1], y[data_w-1:1]};
            end
         end
      endcase
      f = prev;                                      // shifts keep the old word
      if (w.rr.op != op_sra && w.rr.op != op_srl && w.rr.op != op_sll) begin
         f[flag_z] = (y == 16'd0);
         f[flag_v] = v;
         f[flag_n] = arith && y[data_w-1];
      end
      return {f, y};
   endfunction

   always @(posedge clk) begin
      instr_u             w;
      logic [data_w-1:0]  exp_data;
      logic [flags_w-1:0] exp_flags;
      if (!arst_n) begin
         for (int i = 0; i < reg_count; i++) model_regs[i] = '0;
         model_flags = '0;
         pending.delete();
         errors <= 0;
         beats  <= 0;
      end else begin
         if (out_valid) begin
            beats <= beats + 1;
            if (pending.size() == 0) begin
               $display("result beat at time %0t with no instruction outstanding", $time);
               errors <= errors + 1;
            end else begin
               w = pending.pop_front();
               {exp_flags, exp_data} = expected_beat(w, model_regs[w.rr.rs1],
                                                     model_regs[w.rr.rs2], model_flags);
               model_regs[w.rr.rd] = exp_data;
               model_flags         = exp_flags;
               if (out_rd !== w.rr.rd || out_data !== exp_data || out_flags !== exp_flags) begin
                  $display("FAILED at time %0t: %h gave r%0d=%h f=%b, expected r%0d=%h f=%b",
                           $time, w, out_rd, out_data, out_flags, w.rr.rd, exp_data, exp_flags);
                  errors <= errors + 1;
               end
            end
         end
         if (in_valid) pending.push_back(in_instr);   // taken by the input queue
      end
   end

endmodule

// ==== tests/alu_core_tb.sv ====
// testbench for the alu core, credit-paced instruction stimulus and random result credit return
`timescale 1ns/10ps

module alu_core_tb;
   import alu_pkg::*;

   localparam int in_depth    = 4;
   localparam int out_credits = 2;
   localparam int wait_limit  = 3000;   // cycles allowed per wait loop

   logic                 clk = 1'b0;
   logic                 arst_n;
   logic                 in_valid;
   logic [data_w-1:0]    in_instr;
   logic                 in_credit;
   logic                 out_valid;
   logic [reg_idx_w-1:0] out_rd;
   logic [data_w-1:0]    out_data;
   logic [flags_w-1:0]   out_flags;
   logic                 out_credit = 1'b0;
   logic                 hold;                   // consumer keeps its credits
   logic [15:0]          stim_lfsr = 16'd59;     // instruction stream
   logic [15:0]          cred_lfsr = 16'd59;     // credit return gaps
   int                   sent = 0;               // words handed to the DUT
   int                   returned = 0;           // in_credit pulses seen
   int                   owed = 0;               // result credits held by the consumer
   int                   gap = 0;
   int                   mismatches;
   int                   beats;
   int                   timeouts = 0;
   int                   hold_errors = 0;
   int                   base;

   always #10 clk = ~clk;

   alu_core_top #(.in_depth(in_depth), .out_credits(out_credits)) UUT (
      .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_instr(in_instr),
      .in_credit(in_credit), .out_valid(out_valid), .out_rd(out_rd), .out_data(out_data),
      .out_flags(out_flags), .out_credit(out_credit)
   );

   alu_core_checker watcher (
      .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_instr(in_instr),
      .out_valid(out_valid), .out_rd(out_rd), .out_data(out_data), .out_flags(out_flags),
      .errors(mismatches), .beats(beats)
   );

   bind alu_result alu_core_asserts #(.out_credits(out_credits)) u_asserts (
      .clk(clk), .arst_n(arst_n), .out_valid(out_valid), .out_credit(out_credit),
      .ret_ready(ret.ready), .credit_cnt(credit_cnt)
   );

   // galois lfsr, one step per bit handed out
   function automatic logic [15:0] lfsr_take(inout logic [15:0] state, input int nbits);
      logic [15:0] bits;
      bits = '0;
      for (int i = 0; i < nbits; i++) begin
         bits  = {bits[14:0], state[0]};
         state = state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
      end
      return bits;
   endfunction

   function automatic logic [15:0] rr_word(input logic [2:0] op, rd, rs1, rs2);
      return {op, 1'b0, rd, rs1, rs2, 3'b000};
   endfunction

   function automatic logic [15:0] ri_word(input logic [2:0] op, rd, rs1, input logic [5:0] imm);
      return {op, 1'b1, rd, rs1, imm};
   endfunction

   always @(posedge clk) begin
      if (!arst_n) returned <= 0;
      else if (in_credit) returned <= returned + 1;   // sender regains a slot
   end

   // consumer, gives back one credit per beat after a random gap
   always @(posedge clk) begin
      int next_owed;
      next_owed = owed + int'(out_valid);
      out_credit <= 1'b0;
      if (!arst_n) begin
         next_owed = 0;
         gap <= 0;
      end else if (gap != 0) begin
         gap <= gap - 1;
      end else if (!hold && next_owed != 0) begin
         out_credit <= 1'b1;
         next_owed--;
         gap <= int'(lfsr_take(cred_lfsr, 3));   // 0..7 idle cycles
      end
      owed <= next_owed;
   end

   task automatic send_word(input logic [15:0] w);
      int cycles;
      cycles = 0;
      @(posedge clk);
      while (in_depth - sent + returned <= 0 && cycles < wait_limit) begin
         in_valid <= 1'b0;                       // out of credits
         cycles++;
         @(posedge clk);
      end
      if (cycles >= wait_limit) begin
         $display("timeout: no input credit came back for word %h", w);
         timeouts++;
      end else begin
         in_valid <= 1'b1;
         in_instr <= w;
         sent++;
      end
   endtask

   task automatic stop_sending();
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic wait_results();
      int cycles;
      cycles = 0;
      while (beats != sent && cycles < wait_limit) begin
         @(posedge clk);
         cycles++;
      end
      if (beats != sent) begin
         $display("timeout: only %0d of %0d results arrived", beats, sent);
         timeouts++;
      end
   endtask

   task automatic wait_credits_home();
      int cycles;
      cycles = 0;
      while (owed != 0 && cycles < wait_limit) begin
         @(posedge clk);
         cycles++;
      end
      if (owed != 0) begin
         $display("timeout: consumer still holds %0d credits", owed);
         timeouts++;
      end
      @(posedge clk);                             // last pulse lands in the DUT
   endtask

   initial begin
      arst_n   <= 1'b0;
      in_valid <= 1'b0;
      in_instr <= '0;
      hold     <= 1'b0;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      // add, sub, inc with carry, borrow, zero and sign
      send_word(ri_word(op_add, 3'd1, 3'd0, 6'd5));
      send_word(ri_word(op_add, 3'd2, 3'd0, 6'h3d));   // -3
      send_word(rr_word(op_add, 3'd3, 3'd1, 3'd2));
      send_word(rr_word(op_sub, 3'd4, 3'd1, 3'd2));
      send_word(rr_word(op_sub, 3'd5, 3'd1, 3'd1));
      send_word(ri_word(op_add, 3'd7, 3'd0, 6'h3f));   // -1
      send_word(rr_word(op_inc, 3'd6, 3'd7, 3'd0));
      send_word(rr_word(op_inc, 3'd6, 3'd2, 3'd0));
      // andn and xor
      send_word(rr_word(op_andn, 3'd1, 3'd7, 3'd2));
      send_word(rr_word(op_xor, 3'd3, 3'd2, 3'd7));
      send_word(rr_word(op_xor, 3'd5, 3'd3, 3'd1));
      send_word(ri_word(op_andn, 3'd4, 3'd7, 6'h3f));
      // shifts keep the flag word of the add before them
      send_word(ri_word(op_add, 3'd2, 3'd0, 6'h3d));
      send_word(ri_word(op_sra, 3'd4, 3'd2, 6'd2));
      send_word(rr_word(op_srl, 3'd5, 3'd2, 3'd1));
      send_word(ri_word(op_sll, 3'd6, 3'd7, 6'h2f));   // amount 15
      send_word(ri_word(op_srl, 3'd5, 3'd7, 6'h10));   // amount 0
      // dependent chain, no gaps
      send_word(rr_word(op_inc, 3'd1, 3'd1, 3'd0));
      send_word(rr_word(op_add, 3'd2, 3'd2, 3'd1));
      send_word(rr_word(op_sub, 3'd1, 3'd2, 3'd1));
      send_word(rr_word(op_xor, 3'd3, 3'd1, 3'd2));
      send_word(ri_word(op_sll, 3'd3, 3'd3, 6'd1));
      send_word(rr_word(op_add, 3'd3, 3'd3, 3'd3));
      stop_sending();
      wait_results();
      // credits withheld, only the granted ones may produce beats
      wait_credits_home();
      hold <= 1'b1;
      base = beats;
      for (int i = 1; i < 7; i++) begin
         send_word(ri_word(op_add, 3'(i), 3'(i), 6'd1));
      end
      stop_sending();
      repeat (60) @(posedge clk);
      if (beats - base != out_credits) begin
         $display("FAILED at time %0t: %0d beats while credits held, expected %0d",
                  $time, beats - base, out_credits);
         hold_errors++;
      end
      hold <= 1'b0;
      wait_results();
      // random stream
      for (int i = 0; i < 300; i++) begin
         send_word(lfsr_take(stim_lfsr, 16));
      end
      stop_sending();
      wait_results();
      repeat (4) @(posedge clk);
      $display("errors: %0d mismatches, %0d hold violations, %0d timeouts",
               mismatches, hold_errors, timeouts);
      if (mismatches + hold_errors + timeouts == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
